/* rtl/bus_arb_pkg.sv */
package bus_arb_pkg;

    // Bus sizes
    localparam int NO_MASTERS  = 4;
    localparam int NO_SLAVES   = 3;
    localparam int M_ID_WIDTH  = $clog2(NO_MASTERS);      // 2 bits
    localparam int S_ID_WIDTH  = $clog2(NO_SLAVES + 1);   // Slave 0 means no request

    // Cycles a grant is held before split arbitration may hand the bus away
    localparam int SPLIT_LIMIT = 8;
    localparam int HOLD_WIDTH  = $clog2(SPLIT_LIMIT + 1); // Must reach SPLIT_LIMIT itself

    typedef logic [M_ID_WIDTH-1:0] master_id_t;
    typedef logic [S_ID_WIDTH-1:0] slave_id_t;
    typedef logic [HOLD_WIDTH-1:0] hold_cnt_t;

    // One slave id per master with entry 0 in the low bits
    typedef slave_id_t [NO_MASTERS-1:0] req_vec_t;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

    // Current owner of the bus
    typedef struct packed {
        logic       valid;
        master_id_t master;
        slave_id_t  slave;
    } grant_t;

    // Clears one pending entry in the request register
    typedef struct packed {
        logic       valid;
        master_id_t master;
    } release_t;

endpackage : bus_arb_pkg

/* rtl/request_register.sv */
`timescale 1ns/100ps

module request_register (
    input  logic                  clk,
    input  logic                  reset,
    input  bus_arb_pkg::req_vec_t req_slave,
    input  bus_arb_pkg::release_t release_req,
    output bus_arb_pkg::req_vec_t pending
);

    import bus_arb_pkg::*;

    // Each entry holds its slave id until the controller releases it
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            for (int m = 0; m < NO_MASTERS; m++) begin
                if (release_req.valid && (release_req.master == master_id_t'(m))) begin
                    pending[m] <= '0;                // Release beats a new load
                end else if ((pending[m] == '0) && (req_slave[m] != '0)) begin
                    pending[m] <= req_slave[m];      // Only an empty entry accepts a request
                end
            end
        end
    end

    // A release always names the master being served so its entry is full
    a_release_full: assert property (
        @(posedge clk) disable iff (reset)
        release_req.valid |-> (pending[release_req.master] != '0)
    ) else $error("Release of empty entry for master %0d", release_req.master);

endmodule : request_register

/* rtl/priority_selector.sv */
`timescale 1ns/100ps

module priority_selector (
    input  bus_arb_pkg::arb_state_e state,
    input  bus_arb_pkg::grant_t     current,
    input  logic                    split,
    input  bus_arb_pkg::req_vec_t   pending,
    output bus_arb_pkg::master_id_t next_master,
    output bus_arb_pkg::slave_id_t  next_slave,
    output logic                    any_request
);

    import bus_arb_pkg::*;

    logic [NO_MASTERS-1:0] eligible;    // Masters allowed to take the bus now

    assign any_request = |pending;

    // Which masters qualify depends on the controller state
    always_comb begin : eligible_check
        eligible = '0;
        unique case (state)
            ARB_IDLE: begin
                for (int m = 0; m < NO_MASTERS; m++) begin
                    eligible[m] = (pending[m] != '0);
                end
            end
            ARB_BUSY: begin
                for (int m = 0; m < NO_MASTERS; m++) begin
                    if (split) begin
                        // Split transaction lets in any master wanting another slave
                        eligible[m] = (pending[m] != '0) && (pending[m] != current.slave);
                    end else begin
                        eligible[m] = (pending[m] != '0) && (master_id_t'(m) < current.master);
                    end
                end
            end
        endcase
    end

    // Lowest index wins or the current grant stays
    always_comb begin : master_slave_pick
        logic found;
        found       = 1'b0;
        next_master = current.master;
        next_slave  = current.slave;
        for (int m = 0; m < NO_MASTERS; m++) begin
            if (eligible[m] && !found) begin
                next_master = master_id_t'(m);
                next_slave  = pending[m];
                found       = 1'b1;                  // Ignore lower priority masters
            end
        end
    end

endmodule : priority_selector

/* rtl/arbiter_controller.sv */
`timescale 1ns/100ps

module arbiter_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  bus_arb_pkg::req_vec_t   pending,
    input  bus_arb_pkg::master_id_t next_master,
    input  bus_arb_pkg::slave_id_t  next_slave,
    input  logic                    any_request,
    input  logic                    done,
    output bus_arb_pkg::arb_state_e state,
    output logic                    split,
    output bus_arb_pkg::grant_t     grant,
    output bus_arb_pkg::release_t   release_req
);

    import bus_arb_pkg::*;

    hold_cnt_t hold_cnt;    // Cycles the current grant has been held

    assign split = (hold_cnt == hold_cnt_t'(SPLIT_LIMIT));

    // Done only counts while a master owns the bus
    assign release_req.valid  = done && (state == ARB_BUSY);
    assign release_req.master = grant.master;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ARB_IDLE;
            grant    <= '0;
            hold_cnt <= '0;
        end else begin
            unique case (state)
                ARB_IDLE: begin
                    if (any_request) begin
                        state        <= ARB_BUSY;
                        grant.valid  <= 1'b1;
                        grant.master <= next_master;
                        grant.slave  <= next_slave;
                        hold_cnt     <= '0;
                    end
                end
                ARB_BUSY: begin
                    if (done) begin
                        state       <= ARB_IDLE;   // Bus is free for one cycle
                        grant.valid <= 1'b0;
                    end else if (next_master != grant.master) begin
                        grant.master <= next_master;  // Preemption or split handover
                        grant.slave  <= next_slave;
                        hold_cnt     <= '0;
                    end else if (!split) begin
                        hold_cnt <= hold_cnt + 1'b1;  // Saturates at SPLIT_LIMIT
                    end
                end
            endcase
        end
    end

    a_slave_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        grant.valid |-> (grant.slave != '0)
    ) else $error("Grant to slave zero");

    // The owner's request stays in stage 1 until done releases it
    a_owner_pending: assert property (
        @(posedge clk) disable iff (reset)
        (state == ARB_BUSY) |-> (pending[grant.master] != '0)
    ) else $error("Master %0d granted without a pending request", grant.master);

endmodule : arbiter_controller

/* rtl/bus_arbiter_top.sv */
`timescale 1ns/100ps

module bus_arbiter_top (
    input  logic                  clk,
    input  logic                  reset,
    input  bus_arb_pkg::req_vec_t req_slave,
    input  logic                  done,
    output bus_arb_pkg::grant_t   grant
);

    import bus_arb_pkg::*;

    req_vec_t   pending;        // Stage 1 to stages 2 and 3
    release_t   release_req;    // Stage 3 back to stage 1
    arb_state_e state;
    logic       split;
    master_id_t next_master;
    slave_id_t  next_slave;
    logic       any_request;

    request_register u_request_register (
        .clk         (clk),
        .reset       (reset),
        .req_slave   (req_slave),
        .release_req (release_req),
        .pending     (pending)
    );

    priority_selector u_priority_selector (
        .state       (state),
        .current     (grant),
        .split       (split),
        .pending     (pending),
        .next_master (next_master),
        .next_slave  (next_slave),
        .any_request (any_request)
    );

    arbiter_controller u_arbiter_controller (
        .clk         (clk),
        .reset       (reset),
        .pending     (pending),
        .next_master (next_master),
        .next_slave  (next_slave),
        .any_request (any_request),
        .done        (done),
        .state       (state),
        .split       (split),
        .grant       (grant),
        .release_req (release_req)
    );

endmodule : bus_arbiter_top

/* include/arb_ref_model.svh */
`ifndef ARB_REF_MODEL_SVH
`define ARB_REF_MODEL_SVH

// Reference model of the bus arbiter, stepped once per rising clock edge
slave_id_t  mdl_pending [NO_MASTERS];    // Requests waiting to be served
arb_state_e mdl_state;
grant_t     mdl_grant;
int         mdl_hold;                    // Cycles the grant has been held

// Next owner or the current grant when no master qualifies
function automatic void model_pick(output master_id_t who, output slave_id_t what);
    logic found;
    logic ok;
    found = 1'b0;
    who   = mdl_grant.master;
    what  = mdl_grant.slave;
    for (int m = 0; m < NO_MASTERS; m++) begin
        if (mdl_state == ARB_IDLE) begin
            ok = (mdl_pending[m] != '0);
        end else if (mdl_hold == SPLIT_LIMIT) begin
            ok = (mdl_pending[m] != '0) && (mdl_pending[m] != mdl_grant.slave);  // Split
        end else begin
            ok = (mdl_pending[m] != '0) && (m < int'(mdl_grant.master));         // Preempt
        end
        if (ok && !found) begin
            who   = master_id_t'(m);
            what  = mdl_pending[m];
            found = 1'b1;
        end
    end
endfunction

// Advances the model by one edge with the inputs seen at that edge
function automatic void model_step(input logic rst, input req_vec_t req, input logic fin);
    master_id_t nxt_master;
    slave_id_t  nxt_slave;
    master_id_t rel_master;
    logic       any;
    logic       rel;
    if (rst) begin
        foreach (mdl_pending[m]) mdl_pending[m] = '0;
        mdl_state = ARB_IDLE;
        mdl_grant = '0;
        mdl_hold  = 0;
        return;
    end
    model_pick(nxt_master, nxt_slave);
    any = 1'b0;
    foreach (mdl_pending[m]) any = any || (mdl_pending[m] != '0);
    rel        = fin && (mdl_state == ARB_BUSY);  // Done while idle does nothing
    rel_master = mdl_grant.master;
    for (int m = 0; m < NO_MASTERS; m++) begin
        if (rel && (int'(rel_master) == m)) begin
            mdl_pending[m] = '0;
        end else if ((mdl_pending[m] == '0) && (req[m] != '0)) begin
            mdl_pending[m] = req[m];
        end
    end
    if (mdl_state == ARB_IDLE) begin
        if (any) begin
            mdl_state        = ARB_BUSY;
            mdl_grant.valid  = 1'b1;
            mdl_grant.master = nxt_master;
            mdl_grant.slave  = nxt_slave;
            mdl_hold         = 0;
        end
    end else if (fin) begin
        mdl_state       = ARB_IDLE;
        mdl_grant.valid = 1'b0;
    end else if (nxt_master != mdl_grant.master) begin
        mdl_grant.master = nxt_master;
        mdl_grant.slave  = nxt_slave;
        mdl_hold         = 0;
    end else if (mdl_hold < SPLIT_LIMIT) begin
        mdl_hold = mdl_hold + 1;
    end
endfunction

`endif

/* tb/tb_bus_arbiter.sv */
`timescale 1ns/100ps

module tb_bus_arbiter;

    import bus_arb_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 8;      // Idle bus right after reset
    localparam int NUM_CYCLES   = 4000;
    localparam int DRIVE_DELAY  = 1;
    localparam int SEED         = 25526;

    logic     clk;
    logic     reset;
    req_vec_t req_slave;
    logic     done;
    grant_t   grant;

    `include "arb_ref_model.svh"

    bus_arbiter_top DUT (
        .clk       (clk),
        .reset     (reset),
        .req_slave (req_slave),
        .done      (done),
        .grant     (grant)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Each master asks for a random slave now and then
    function automatic req_vec_t random_requests();
        req_vec_t r;
        for (int m = 0; m < NO_MASTERS; m++) begin
            if (($urandom % 8) == 0) begin
                r[m] = slave_id_t'(1 + ($urandom % NO_SLAVES));
            end else begin
                r[m] = '0;
            end
        end
        return r;
    endfunction

    // Master and slave only matter while the grant is valid
    task automatic check_grant();
        assert ((grant.valid == mdl_grant.valid) &&
                (!mdl_grant.valid ||
                 ((grant.master == mdl_grant.master) && (grant.slave == mdl_grant.slave))))
        else begin
            $display("Mismatch at %0t: expected valid=%0b master=%0d slave=%0d",
                     $time, mdl_grant.valid, mdl_grant.master, mdl_grant.slave);
            $display("Mismatch at %0t: actual   valid=%0b master=%0d slave=%0d",
                     $time, grant.valid, grant.master, grant.slave);
            $display("Errors found");
            $fatal(1, "Grant differs from the reference model");
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req_slave = '0;
        done      = 1'b0;
        void'($urandom(SEED));

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clk);
            model_step(reset, req_slave, done);    // Inputs are stable at the edge
            #DRIVE_DELAY;
            check_grant();
            reset = (cycle < RESET_CYCLES - 1);
            if (cycle < RESET_CYCLES + QUIET_CYCLES) begin
                req_slave = '0;
                done      = 1'b0;
            end else begin
                req_slave = random_requests();
                // One-cycle done only while a master owns the bus
                done      = grant.valid && !done && (($urandom % 12) == 0);
            end
        end

        $display("No errors");
        $finish;
    end

    // Stops a run that goes past its expected length
    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: the simulation ran past its expected length");
        $display("Errors found");
        $fatal(1, "Watchdog expired");
    end

endmodule : tb_bus_arbiter

/* compile.f */
+incdir+include
rtl/bus_arb_pkg.sv
rtl/request_register.sv
rtl/priority_selector.sv
rtl/arbiter_controller.sv
rtl/bus_arbiter_top.sv
tb/tb_bus_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bus arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_bus_arbiter -o sim_bus_arbiter
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_bus_arbiter 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
